/* src/pool_params.svh */
// ====================
// pooling path parameters
// line buffer depth and pixel and word widths
// ====================
`ifndef POOL_PARAMS_SVH
`define POOL_PARAMS_SVH

// largest number of input words in one row, sets line buffer depth
`define POOL_MAX_HALF_W 64

// one signed feature pixel
`define POOL_PIX_W 16

// one stream word, two pixels side by side
`define POOL_WORD_W 32

`endif

/* src/pool_data_pkg.sv */
// ====================
// pooling data types
// pixel, stream word and frame dimension vectors
// ====================
`include "pool_params.svh"

package pool_data_pkg;

  // signed feature pixel
  typedef logic signed [`POOL_PIX_W-1:0] pixel_t;

  // stream word, lower half is the left pixel
  typedef logic [`POOL_WORD_W-1:0] word_t;

  // frame dimension in words or rows
  typedef logic [15:0] dim_t;

endpackage

/* src/pool_ctrl_pkg.sv */
// ====================
// pooling control types
// FSM states of the frame stage and the packer
// ====================
package pool_ctrl_pkg;

  // frame stage: wait for start, stream a frame, wait for start to drop
  typedef enum logic [1:0] {FR_IDLE, FR_RUN, FR_DRAIN} frame_state_e;

  // packer: which output half is filled next
  typedef enum logic {PK_LOW, PK_HIGH} pack_state_e;

endpackage

/* src/pool_stream_if.sv */
`timescale 1ns/10ps
// ====================
// pooling stream link
// valid/ready handshake with data and frame last
// ====================
interface pool_stream_if;
  import pool_data_pkg::*;

  logic  valid;  // source has a word
  logic  ready;  // sink takes it this edge
  word_t data;   // two pixels
  logic  last;   // final word of the frame

  // producing side
  modport src (
    output valid,
    output data,
    output last,
    input  ready
  );

  // consuming side
  modport snk (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

/* src/frame_pipe_stage.sv */
`timescale 1ns/10ps
// ====================
// frame pipeline stage
// frames the engine output by width and height and holds
// one word at a time in front of the pooling path
// ====================
module frame_pipe_stage (
  input  logic                 clk_gated,
  input  logic                 rst_n,
  input  logic                 start_i,       // start level from the engine
  input  pool_data_pkg::dim_t  half_width_i,  // words per row
  input  pool_data_pkg::dim_t  height_i,      // rows per frame
  input  logic                 in_valid_i,
  input  pool_data_pkg::word_t in_data_i,
  output logic                 in_ready_o,
  pool_stream_if.src           out_o
);
  import pool_data_pkg::*;
  import pool_ctrl_pkg::*;

  frame_state_e state_q;
  dim_t         col_q;        // word index in the row
  dim_t         row_q;        // row index in the frame
  word_t        hold_data_q;  // single holding register
  logic         hold_vld_q;
  logic         hold_last_q;
  logic         fin_q;        // final word of the frame already taken
  logic         row_end;
  logic         frame_end;
  logic         in_fire;
  logic         out_fire;

  // counter decode
  assign row_end   = (col_q == half_width_i - dim_t'(1));
  assign frame_end = row_end && (row_q == height_i - dim_t'(1));

  // held word leaves this edge
  assign out_fire = hold_vld_q && out_o.ready;

  // take a word when the register is free or being emptied, never after frame end
  assign in_ready_o = (state_q == FR_RUN) && !fin_q && (!hold_vld_q || out_o.ready);
  assign in_fire    = in_valid_i && in_ready_o;

  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      state_q     <= FR_IDLE;
      col_q       <= '0;
      row_q       <= '0;
      hold_vld_q  <= 1'b0;
      hold_last_q <= 1'b0;
      fin_q       <= 1'b0;
    end else begin
      case (state_q)
        FR_IDLE: begin
          col_q <= '0;  // fresh frame
          row_q <= '0;
          fin_q <= 1'b0;
          if (start_i) begin
            state_q <= FR_RUN;
          end
        end
        FR_RUN: begin
          if (in_fire) begin
            hold_last_q <= frame_end;  // tag last word of frame
            if (row_end) begin
              col_q <= '0;
              row_q <= row_q + dim_t'(1);
            end else begin
              col_q <= col_q + dim_t'(1);
            end
            if (frame_end) begin
              fin_q <= 1'b1;
            end
          end
          // final word gone downstream
          if (fin_q && out_fire) begin
            state_q <= FR_DRAIN;
          end
        end
        FR_DRAIN: begin
          if (!start_i) begin  // hold off until start drops
            state_q <= FR_IDLE;
          end
        end
        default: state_q <= FR_IDLE;
      endcase

      // holding register occupancy
      if (in_fire) begin
        hold_vld_q <= 1'b1;
      end else if (out_fire) begin
        hold_vld_q <= 1'b0;
      end
    end
  end

  // payload, loaded on every accepted word
  always_ff @(posedge clk_gated) begin
    if (in_fire) begin
      hold_data_q <= in_data_i;
    end
  end

  assign out_o.valid = hold_vld_q;
  assign out_o.data  = hold_data_q;
  assign out_o.last  = hold_last_q;

endmodule

/* src/pool_line_buffer.sv */
`timescale 1ns/10ps
// ====================
// pooling line buffer
// horizontal max per word, keeps even rows and
// pairs them with the odd row below
// ====================
`include "pool_params.svh"

module pool_line_buffer (
  input  logic                clk_gated,
  input  logic                rst_n,
  input  pool_data_pkg::dim_t half_width_i,  // words per row
  pool_stream_if.snk          in_i,
  pool_stream_if.src          out_o
);
  import pool_data_pkg::*;

  localparam int ADDR_W = $clog2(`POOL_MAX_HALF_W);

  pixel_t            row_mem [`POOL_MAX_HALF_W];  // even row maxima
  pixel_t            pix_lo;
  pixel_t            pix_hi;
  pixel_t            hmax;       // horizontal max of the incoming word
  dim_t              col_q;
  logic              odd_q;      // row parity, 1 on odd rows
  logic [ADDR_W-1:0] idx;
  logic              out_vld_q;
  logic              out_last_q;
  word_t             out_data_q;
  logic              in_fire;

  // left pixel sits in the lower half
  assign {pix_hi, pix_lo} = in_i.data;
  assign hmax = (pix_hi > pix_lo) ? pix_hi : pix_lo;  // signed compare
  assign idx  = col_q[ADDR_W-1:0];

  // even rows never produce output so they are not held back
  assign in_i.ready = !odd_q || !out_vld_q || out_o.ready;
  assign in_fire    = in_i.valid && in_i.ready;

  // column and parity tracking, output valid
  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      col_q      <= '0;
      odd_q      <= 1'b0;
      out_vld_q  <= 1'b0;
      out_last_q <= 1'b0;
    end else begin
      if (in_fire) begin
        if (col_q == half_width_i - dim_t'(1)) begin
          col_q <= '0;
          odd_q <= !odd_q;  // next row
        end else begin
          col_q <= col_q + dim_t'(1);
        end
      end

      if (in_fire && odd_q) begin
        out_vld_q  <= 1'b1;
        out_last_q <= in_i.last;
      end else if (out_o.ready) begin
        out_vld_q  <= 1'b0;
        out_last_q <= 1'b0;
      end
    end
  end

  // storage and pair register
  always_ff @(posedge clk_gated) begin
    if (in_fire) begin
      if (!odd_q) begin
        row_mem[idx] <= hmax;
      end else begin
        out_data_q <= {hmax, row_mem[idx]};  // upper is odd row, lower is even row
      end
    end
  end

  assign out_o.valid = out_vld_q;
  assign out_o.data  = out_data_q;
  assign out_o.last  = out_last_q;

endmodule

/* src/pool_max_out.sv */
`timescale 1ns/10ps
// ====================
// pooling output packer
// vertical max of each row pair, two results per output word
// ====================
module pool_max_out (
  input  logic                 clk_gated,
  input  logic                 rst_n,
  pool_stream_if.snk           in_i,
  output logic                 out_valid_o,
  output pool_data_pkg::word_t out_data_o,
  output logic                 out_last_o,
  input  logic                 out_ready_i
);
  import pool_data_pkg::*;
  import pool_ctrl_pkg::*;

  pack_state_e state_q;
  pixel_t      pix_even;   // stored even row max
  pixel_t      pix_odd;    // current odd row max
  pixel_t      vmax;
  pixel_t      low_q;      // first result of the pair
  word_t       out_data_q;
  logic        out_vld_q;
  logic        out_last_q;
  logic        in_fire;

  assign {pix_odd, pix_even} = in_i.data;
  assign vmax = (pix_odd > pix_even) ? pix_odd : pix_even;

  // lower half only goes to a register, upper half needs the output free
  assign in_i.ready = (state_q == PK_LOW) || !out_vld_q || out_ready_i;
  assign in_fire    = in_i.valid && in_i.ready;

  always_ff @(posedge clk_gated) begin
    if (!rst_n) begin
      state_q    <= PK_LOW;
      out_vld_q  <= 1'b0;
      out_last_q <= 1'b0;
    end else begin
      if (in_fire) begin
        state_q <= (state_q == PK_LOW) ? PK_HIGH : PK_LOW;
      end

      if (in_fire && state_q == PK_HIGH) begin
        out_vld_q  <= 1'b1;
        out_last_q <= in_i.last;  // frame end follows the second result
      end else if (out_ready_i) begin
        out_vld_q  <= 1'b0;
        out_last_q <= 1'b0;
      end
    end
  end

  // result registers
  always_ff @(posedge clk_gated) begin
    if (in_fire) begin
      if (state_q == PK_LOW) begin
        low_q <= vmax;
      end else begin
        out_data_q <= {vmax, low_q};
      end
    end
  end

  assign out_valid_o = out_vld_q;
  assign out_data_o  = out_data_q;
  assign out_last_o  = out_last_q;

endmodule

/* src/pool_subsystem_top.sv */
`timescale 1ns/10ps
// ====================
// pooling subsystem
// frame stage, line buffer and output packer, 2x2 max pooling
// ====================
module pool_subsystem_top (
  input  logic                 clk_gated,
  input  logic                 rst_n,
  input  logic                 start_i,       // start level
  input  pool_data_pkg::dim_t  half_width_i,  // input words per row
  input  pool_data_pkg::dim_t  height_i,      // rows per frame
  input  logic                 in_valid_i,    // engine stream
  input  pool_data_pkg::word_t in_data_i,
  output logic                 in_ready_o,
  output logic                 out_valid_o,   // pooled stream
  output pool_data_pkg::word_t out_data_o,
  output logic                 out_last_o,
  input  logic                 out_ready_i
);

  pool_stream_if fr_s ();  // framed words
  pool_stream_if lb_s ();  // odd row pairs

  frame_pipe_stage u_frame (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .half_width_i (half_width_i),
    .height_i     (height_i),
    .in_valid_i   (in_valid_i),
    .in_data_i    (in_data_i),
    .in_ready_o   (in_ready_o),
    .out_o        (fr_s.src)
  );

  pool_line_buffer u_line (
    .clk_gated    (clk_gated),
    .rst_n        (rst_n),
    .half_width_i (half_width_i),
    .in_i         (fr_s.snk),
    .out_o        (lb_s.src)
  );

  pool_max_out u_pack (
    .clk_gated   (clk_gated),
    .rst_n       (rst_n),
    .in_i        (lb_s.snk),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_last_o  (out_last_o),
    .out_ready_i (out_ready_i)
  );

endmodule

/* test/pool_properties.sv */
`timescale 1ns/10ps
// ====================
// stream handshake properties
// reset quiet outputs and steady data under stall
// ====================
`include "pool_params.svh"

module pool_properties (
  input logic                    clk_gated,
  input logic                    rst_n,
  input logic                    valid_i,  // source valid
  input logic                    fire_i,   // transfer this edge
  input logic [`POOL_WORD_W-1:0] data_i,
  input logic                    last_i
);

  int fail_cnt = 0;  // assertion failures so far

  // reset clears the source valid
  property p_quiet_in_reset;
    @(posedge clk_gated) !rst_n |=> !valid_i;
  endproperty

  // a stalled word keeps valid, data and last
  property p_steady_on_stall;
    @(posedge clk_gated) disable iff (!rst_n)
      valid_i && !fire_i |=> valid_i && $stable(data_i) && $stable(last_i);
  endproperty

  a_quiet_in_reset: assert property (p_quiet_in_reset)
    else begin
      $error("valid high right after a reset cycle");
      fail_cnt++;
    end

  a_steady_on_stall: assert property (p_steady_on_stall)
    else begin
      $error("stream word changed while stalled");
      fail_cnt++;
    end

endmodule

/* test/pool_scoreboard.sv */
`timescale 1ns/10ps
// ====================
// pooling scoreboard
// builds 2x2 maxima from accepted input words, checks the output stream
// ====================
`include "pool_params.svh"

module pool_scoreboard (
  input  logic                 clk_gated,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  pool_data_pkg::dim_t  half_width_i,
  input  pool_data_pkg::dim_t  height_i,
  input  logic                 in_valid_i,
  input  pool_data_pkg::word_t in_data_i,
  input  logic                 in_ready_o,
  input  logic                 out_valid_o,
  input  pool_data_pkg::word_t out_data_o,
  input  logic                 out_last_o,
  input  logic                 out_ready_i,
  output int                   err_cnt_o,  // check failures so far
  output int                   out_cnt_o   // output words accepted so far
);
  import pool_data_pkg::*;

  pixel_t      even_row [`POOL_MAX_HALF_W];  // horizontal maxima of the even row
  logic [32:0] exp_q [$];                    // {last, word} in output order
  pixel_t      low_res;                      // first result of a pair
  int          col = 0;
  int          row = 0;
  int          res_idx = 0;                  // pooled pixel index in the frame
  int          rst_cyc = 0;
  logic        rst_d = 1'b0;
  logic        frame_held = 1'b0;            // frame taken, start still high

  initial begin
    err_cnt_o = 0;
    out_cnt_o = 0;
  end

  function automatic pixel_t max2(input pixel_t a, input pixel_t b);
    return (a > b) ? a : b;  // signed
  endfunction

  always @(posedge clk_gated) begin
    pixel_t      hm;
    pixel_t      vm;
    logic [32:0] got;
    logic [32:0] exp_w;
    int          total;
    // quiet outputs during reset and on the first cycle after
    if ((!rst_n && rst_cyc > 0) || (rst_n && !rst_d && rst_cyc > 0)) begin
      if (in_ready_o !== 1'b0 || out_valid_o !== 1'b0) begin
        $display("Error at %0t: in_ready or out_valid not low around reset", $time);
        err_cnt_o++;
      end
    end
    if (!rst_n) begin
      rst_cyc++;
      col = 0;
      row = 0;
      res_idx = 0;
      frame_held = 1'b0;
      exp_q.delete();
    end else begin
      // no new frame while start stays high
      if (frame_held && start_i && in_ready_o) begin
        $display("Error at %0t: in_ready high before start fell", $time);
        err_cnt_o++;
      end
      if (!start_i) frame_held = 1'b0;
      if (in_valid_i && in_ready_o) begin
        total = int'(half_width_i) * (int'(height_i) / 2);
        hm = max2(in_data_i[31:16], in_data_i[15:0]);
        if (row % 2 == 0) begin
          even_row[col] = hm;
        end else begin
          vm = max2(even_row[col], hm);
          if (res_idx % 2 == 0) low_res = vm;
          else exp_q.push_back({(res_idx == total - 1), vm, low_res});
          res_idx++;
        end
        col++;
        if (col == int'(half_width_i)) begin  // row done
          col = 0;
          row++;
          if (row == int'(height_i)) begin
            row = 0;
            res_idx = 0;
            frame_held = 1'b1;
          end
        end
      end
      if (out_valid_o && out_ready_i) begin
        out_cnt_o++;
        got = {out_last_o, out_data_o};
        if (exp_q.size() == 0) begin
          $display("Error at %0t: unexpected output word %h", $time, out_data_o);
          err_cnt_o++;
        end else begin
          exp_w = exp_q.pop_front();
          if (got !== exp_w) begin
            $display("Error at %0t: output last/word %h, expected %h", $time, got, exp_w);
            err_cnt_o++;
          end
        end
      end
    end
    rst_d = rst_n;
  end

endmodule

/* test/tb_pool_subsystem.sv */
`timescale 1ns/10ps
// ====================
// pooling subsystem testbench
// frame table, random back-pressure, summary
// ====================
module tb_pool_subsystem;
  import pool_data_pkg::*;

  localparam int N_TESTS = 6;
  localparam int TMO = 2000;  // cycles per wait

  logic  clk_gated = 1'b0;
  logic  rst_n = 1'b0;
  logic  start_i = 1'b0;
  dim_t  half_width_i = '0;
  dim_t  height_i = '0;
  logic  in_valid_i = 1'b0;
  word_t in_data_i = '0;
  logic  in_ready_o;
  logic  out_valid_o;
  word_t out_data_o;
  logic  out_last_o;
  logic  out_ready_i = 1'b0;
  int    err_cnt;
  int    out_cnt;

  // frame table of half width, height, out_ready percent and pooled words
  int tab_hw [N_TESTS] = '{2, 4, 8, 6, 16, 4};
  int tab_h [N_TESTS] = '{2, 2, 4, 6, 2, 8};
  int tab_prob [N_TESTS] = '{100, 70, 50, 30, 90, 60};
  int tab_words [N_TESTS] = '{1, 2, 8, 9, 8, 8};  // (hw / 2) * (h / 2)

  logic [31:0] data_rng = 32'd81;
  logic [31:0] rdy_rng = 32'd81 ^ 32'h5a5a_a5a5;  // separate ready stream
  int          ready_prob = 100;
  logic        timed_out = 1'b0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          exp_out = 0;  // cumulative expected output words

  pool_subsystem_top DUT (.*);

  pool_scoreboard u_sb (.*, .err_cnt_o(err_cnt), .out_cnt_o(out_cnt));

  bind frame_pipe_stage pool_properties u_fr_props (
    .clk_gated(clk_gated), .rst_n(rst_n), .valid_i(hold_vld_q),
    .fire_i(out_fire), .data_i(hold_data_q), .last_i(hold_last_q)
  );
  bind pool_max_out pool_properties u_out_props (
    .clk_gated(clk_gated), .rst_n(rst_n), .valid_i(out_valid_o),
    .fire_i(out_valid_o && out_ready_i), .data_i(out_data_o), .last_i(out_last_o)
  );

  always #5 clk_gated = !clk_gated;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  // failures in both bound property checkers
  function automatic int assert_fails();
    return DUT.u_frame.u_fr_props.fail_cnt + DUT.u_pack.u_out_props.fail_cnt;
  endfunction

  // random back-pressure that changes on the falling edge
  always @(negedge clk_gated) begin
    rdy_rng = xorshift32(rdy_rng);
    out_ready_i = rst_n && ((rdy_rng % 100) < ready_prob);
  end

  // hold one word from a falling edge until the DUT takes it
  task automatic send_word(input word_t w);
    int   t;
    logic taken;
    t = 0;
    taken = 1'b0;
    in_valid_i = 1'b1;
    in_data_i = w;
    while (!taken && t < TMO) begin
      #1 taken = in_ready_o;  // stable until the rising edge
      @(posedge clk_gated);
      @(negedge clk_gated);
      t++;
    end
    in_valid_i = 1'b0;
    if (!taken) begin
      $display("timeout: input word was never accepted");
      timed_out = 1'b1;
    end
  endtask

  initial begin
    int err_before;
    int out_before;
    int prop_before;
    int t;
    repeat (4) @(negedge clk_gated);
    rst_n = 1'b1;
    @(negedge clk_gated);
    for (int i = 0; i < N_TESTS && !timed_out; i++) begin
      err_before = err_cnt;
      out_before = out_cnt;
      prop_before = assert_fails();
      half_width_i = dim_t'(tab_hw[i]);
      height_i = dim_t'(tab_h[i]);
      ready_prob = tab_prob[i];
      exp_out += tab_words[i];
      start_i = 1'b1;
      for (int n = 0; n < tab_hw[i] * tab_h[i] && !timed_out; n++) begin
        data_rng = xorshift32(data_rng);
        send_word(data_rng);
      end
      t = 0;
      while (out_cnt < exp_out && t < TMO) begin  // drain the pooled words
        @(negedge clk_gated);
        t++;
      end
      if (out_cnt < exp_out) begin
        $display("timeout: frame %0d gave too few output words", i);
        timed_out = 1'b1;
      end
      // offered words are refused while start stays high
      in_valid_i = 1'b1;
      repeat (6) @(negedge clk_gated);
      in_valid_i = 1'b0;
      start_i = 1'b0;
      repeat (2) @(negedge clk_gated);
      if (err_cnt == err_before && out_cnt == exp_out && !timed_out &&
          assert_fails() == prop_before) begin
        n_pass++;
        $display("test %0d hw=%0d h=%0d words=%0d: ok", i, tab_hw[i], tab_h[i],
                 out_cnt - out_before);
      end else begin
        n_fail++;
        $display("test %0d hw=%0d h=%0d words=%0d: FAIL", i, tab_hw[i], tab_h[i],
                 out_cnt - out_before);
      end
    end
    $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             n_pass, n_fail, err_cnt, assert_fails());
    if (n_fail == 0 && err_cnt == 0 && assert_fails() == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+src
src/pool_data_pkg.sv
src/pool_ctrl_pkg.sv
src/pool_stream_if.sv
src/frame_pipe_stage.sv
src/pool_line_buffer.sv
src/pool_max_out.sv
src/pool_subsystem_top.sv
test/pool_properties.sv
test/pool_scoreboard.sv
test/tb_pool_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pooling testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_pool_subsystem \
  -o vsim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/vsim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation ok"
